/* Bender.yml */
package:
  name: obi_mon

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/obi_pkg.sv
      - rtl/mon_pkg.sv
      - rtl/obi_req_capture.sv
      - rtl/obi_req_attr_fifo.sv
      - rtl/obi_resp_pair.sv
      - rtl/obi_mon_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_obi_mon.sv

/* list.f */
+incdir+rtl
rtl/obi_pkg.sv
rtl/mon_pkg.sv
rtl/obi_req_capture.sv
rtl/obi_req_attr_fifo.sv
rtl/obi_resp_pair.sv
rtl/obi_mon_top.sv
test/tb_obi_mon.sv

/* rtl/mon_pkg.sv */
// Monitor types: request attribute record and fault code enumeration.

`include "obi_mon_macros.svh"

package mon_pkg;

  import obi_pkg::*;

  // ==================================================
  // Request attributes
  // ==================================================

  // What the monitor remembers about a granted request
  // until its response comes back.
  typedef struct packed {
    obi_addr_t addr; // Request address.
    logic      we;   // Write enable, 1 for stores.
    obi_be_t   be;   // Byte enables.
  } req_attr_t;

  // ==================================================
  // Protocol faults
  // ==================================================

  // Reported as a one-cycle strobe with this code.
  typedef enum logic [1:0] {
    fault_none     = 2'd0, // No fault this cycle.
    fault_overflow = 2'd1, // Grant while tracking FIFO full.
    fault_orphan   = 2'd2  // Response with nothing outstanding.
  } mon_fault_e;

endpackage : mon_pkg

/* rtl/obi_mon_macros.svh */
// Width and depth macros for the OBI data port monitor.

`ifndef OBI_MON_MACROS_SVH
`define OBI_MON_MACROS_SVH

// ==================================================
// Bus field widths
// ==================================================

// Byte enable width is derived from the data width.
`define OBI_MON_AW 32 // Address width in bits.

`define OBI_MON_DW 32 // Data width in bits.

// ==================================================
// Outstanding request tracking
// ==================================================

// Maximum number of granted requests that may still
// be waiting for their response.
`define OBI_MON_DEPTH 2 // Two outstanding, as on the core port.

`endif // OBI_MON_MACROS_SVH

/* rtl/obi_mon_top.sv */
// Monitor top level: request capture, attribute FIFO and response pairing.

`timescale 1ns/1ps

`include "obi_mon_macros.svh"

module obi_mon_top
  import obi_pkg::*;
  import mon_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Observed OBI data port.
  input  logic       req,
  input  logic       gnt,
  input  obi_addr_t  addr,
  input  logic       we,
  input  obi_be_t    be,
  input  logic       rvalid,
  input  obi_data_t  rdata,
  input  logic       err,

  // Paired transaction record.
  output logic       txn_valid,
  output obi_addr_t  txn_addr,
  output logic       txn_we,
  output obi_be_t    txn_be,
  output obi_data_t  txn_rdata,
  output logic       txn_err,

  // Protocol faults.
  output logic       fault_valid,
  output mon_fault_e fault_code
);

  logic      push_valid; // Stage 1 to stage 2.
  req_attr_t push_attr;
  logic      pop_valid;  // Stage 3 to stage 2.
  req_attr_t head_attr;  // Stage 2 to stage 3.
  logic      empty;

  // ==================================================
  // Pipeline stages
  // ==================================================

  obi_req_capture capture_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req        (req),
    .gnt        (gnt),
    .addr       (addr),
    .we         (we),
    .be         (be),
    .push_valid (push_valid),
    .push_attr  (push_attr)
  );

  obi_req_attr_fifo #(
    .payload_t (req_attr_t),
    .DEPTH     (`OBI_MON_DEPTH)
  ) fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_valid  (push_valid),
    .push_attr   (push_attr),
    .pop_valid   (pop_valid),
    .head_attr   (head_attr),
    .empty       (empty),
    .fault_valid (fault_valid),
    .fault_code  (fault_code)
  );

  obi_resp_pair pair_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .err       (err),
    .head_attr (head_attr),
    .empty     (empty),
    .pop_valid (pop_valid),
    .txn_valid (txn_valid),
    .txn_addr  (txn_addr),
    .txn_we    (txn_we),
    .txn_be    (txn_be),
    .txn_rdata (txn_rdata),
    .txn_err   (txn_err)
  );

endmodule : obi_mon_top

/* rtl/obi_pkg.sv */
// OBI bus field types: address, data and byte enable.

`include "obi_mon_macros.svh"

package obi_pkg;

  // ==================================================
  // Request phase fields
  // ==================================================

  // Byte address of a transfer.
  typedef logic [`OBI_MON_AW-1:0] obi_addr_t; // Full byte address.

  // One strobe bit per data byte.
  typedef logic [`OBI_MON_DW/8-1:0] obi_be_t; // Byte lane enables.

  // ==================================================
  // Data fields
  // ==================================================

  // Shared by wdata and rdata.
  typedef logic [`OBI_MON_DW-1:0] obi_data_t; // Read or write data.

endpackage : obi_pkg

/* rtl/obi_req_attr_fifo.sv */
// In-order FIFO of outstanding request attributes with overflow and orphan faults.

`timescale 1ns/1ps

`include "obi_mon_macros.svh"

module obi_req_attr_fifo
  import mon_pkg::*;
#(
  parameter type payload_t = req_attr_t,
  parameter int  DEPTH     = `OBI_MON_DEPTH
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Write side, from the request capture stage.
  input  logic       push_valid,
  input  payload_t   push_attr,

  // Read side, towards the response pairing stage.
  input  logic       pop_valid,
  output payload_t   head_attr,
  output logic       empty,

  // Protocol fault strobe.
  output logic       fault_valid,
  output mon_fault_e fault_code
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Slot index width.
  localparam int CNT_W = $clog2(DEPTH + 1);              // Holds 0..DEPTH.

  payload_t         mem [DEPTH]; // Attribute storage.
  logic [PTR_W-1:0] wr_ptr;      // Next free slot.
  logic [PTR_W-1:0] rd_ptr;      // Oldest entry.
  logic [CNT_W-1:0] count;       // Entries held.
  logic             full;
  logic             do_push;     // Accepted write.
  logic             do_pop;      // Accepted read.
  logic             overflow;
  logic             orphan;

  // Wraps a slot index at DEPTH.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ==================================================
  // Status and accept logic
  // ==================================================

  assign full      = (count == CNT_W'(DEPTH));
  assign empty     = (count == '0);
  assign do_push   = push_valid && !full;  // Push to full is dropped.
  assign do_pop    = pop_valid && !empty;  // Pop from empty is ignored.
  assign overflow  = push_valid && full;
  assign orphan    = pop_valid && empty;
  assign head_attr = mem[rd_ptr];          // Oldest request, read in place.

  // ==================================================
  // Storage and pointers
  // ==================================================

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_attr;
    end
  end

  // Push-only, pop-only and push with pop all handled here.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0; // Empty out of reset.
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1; // Push only.
        2'b01:   count <= count - 1'b1; // Pop only.
        default: count <= count;        // Both or neither.
      endcase
    end
  end

  // ==================================================
  // Fault strobe
  // ==================================================

  // Overflow wins if both hit in one cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_valid <= 1'b0;
      fault_code  <= fault_none;
    end else begin
      fault_valid <= overflow || orphan;
      if (overflow) begin
        fault_code <= fault_overflow;
      end else if (orphan) begin
        fault_code <= fault_orphan;
      end else begin
        fault_code <= fault_none;
      end
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count <= CNT_W'(DEPTH)
  ) else $error("attribute FIFO count above depth");

  // Head must hold a real pushed value.
  a_head_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !empty |-> !$isunknown(head_attr)
  ) else $error("attribute FIFO head unknown while not empty");

endmodule : obi_req_attr_fifo

/* rtl/obi_req_capture.sv */
// Request phase capture stage: handshake detect and attribute register.

`timescale 1ns/1ps

`include "obi_mon_macros.svh"

module obi_req_capture
  import obi_pkg::*;
  import mon_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Observed OBI request phase.
  input  logic      req,
  input  logic      gnt,
  input  obi_addr_t addr,
  input  logic      we,
  input  obi_be_t   be,

  // Push strobe towards the attribute FIFO.
  output logic      push_valid,
  output req_attr_t push_attr
);

  logic handshake; // Request accepted this cycle.

  assign handshake = req && gnt;

  // ==================================================
  // Push strobe
  // ==================================================

  // One cycle late, matching the response path delay.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_valid <= 1'b0; // Nothing to push out of reset.
    end else begin
      push_valid <= handshake;
    end
  end

  // Attributes only load on an accepted request.
  always_ff @(posedge clk_i) begin
    if (handshake) begin
      push_attr.addr <= addr; // Address as granted.
      push_attr.we   <= we;
      push_attr.be   <= be;
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  // A pending request may not change its attributes
  // before the slave grants it.
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req && !gnt) |=> ($stable(addr) && $stable(we) && $stable(be))
  ) else $error("request attributes changed while waiting for gnt");

endmodule : obi_req_capture

/* rtl/obi_resp_pair.sv */
// Response phase stage: pops the matching request and emits the transaction record.

`timescale 1ns/1ps

`include "obi_mon_macros.svh"

module obi_resp_pair
  import obi_pkg::*;
  import mon_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Observed OBI response phase.
  input  logic      rvalid,
  input  obi_data_t rdata,
  input  logic      err,

  // From the attribute FIFO.
  input  req_attr_t head_attr,
  input  logic      empty,

  // Pop strobe back to the FIFO.
  output logic      pop_valid,

  // Completed transaction record.
  output logic      txn_valid,
  output obi_addr_t txn_addr,
  output logic      txn_we,
  output obi_be_t   txn_be,
  output obi_data_t txn_rdata,
  output logic      txn_err
);

  obi_data_t rdata_q;  // Response data, one cycle late.
  logic      err_q;    // Response error, one cycle late.
  req_attr_t pair_attr; // Attributes joined to this response.

  // Orphan responses carry zero attributes.
  assign pair_attr = empty ? '0 : head_attr;

  // ==================================================
  // Response register stage
  // ==================================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pop_valid <= 1'b0;
      txn_valid <= 1'b0;
    end else begin
      pop_valid <= rvalid;    // Cycle m+1.
      txn_valid <= pop_valid; // Cycle m+2.
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvalid) begin
      rdata_q <= rdata;
      err_q   <= err;
    end
  end

  // ==================================================
  // Record register stage
  // ==================================================

  always_ff @(posedge clk_i) begin
    if (pop_valid) begin
      txn_addr  <= pair_attr.addr;
      txn_we    <= pair_attr.we;
      txn_be    <= pair_attr.be;
      txn_rdata <= rdata_q;
      txn_err   <= err_q;
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  // Every record leaves with known fields.
  a_txn_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    txn_valid |-> !$isunknown({txn_addr, txn_we, txn_be, txn_rdata, txn_err})
  ) else $error("transaction record has unknown fields");

endmodule : obi_resp_pair

/* test/obi_mon_testdata.txt */
# T <name> starts a test, E ends it, C is one bus cycle in hex:
# C req gnt addr we be rvalid rdata err  (addr is replaced by filler when req is 0)
T reset_idle
C 0 0 00000000 0 0 0 00000000 0
C 0 0 00000000 0 0 0 00000000 0
C 0 0 00000000 0 0 0 00000000 0
C 0 0 00000000 0 0 0 00000000 0
E
T back_to_back
C 1 1 00001000 0 f 0 00000000 0
C 1 1 00001004 0 f 0 00000000 0
C 0 0 00000000 0 0 1 11111111 0
C 0 0 00000000 0 0 1 22222222 0
E
T req_resp_same
C 1 1 00002000 0 3 0 00000000 0
C 1 1 00002010 1 c 1 aaaa5555 0
C 0 0 00000000 0 0 1 bbbb0000 0
E
T write_read_mix
C 1 1 00003000 1 1 0 00000000 0
C 1 1 00003004 0 6 1 00000000 1
C 0 0 00000000 0 0 1 deadbeef 0
C 1 1 00003008 1 8 0 00000000 0
C 0 0 00000000 0 0 1 cafef00d 1
E
T overflow
C 1 1 00004000 0 f 0 00000000 0
C 1 1 00004004 1 3 0 00000000 0
C 1 1 00004008 0 f 0 00000000 0
C 0 0 00000000 0 0 1 44440000 0
C 0 0 00000000 0 0 1 44440004 0
E
T orphan
C 0 0 00000000 0 0 1 55550000 1
C 0 0 00000000 0 0 0 00000000 0
E
T orphan_then_pair
C 1 1 00006000 0 f 1 66660000 0
C 0 0 00000000 0 0 1 66660004 0
E

/* test/tb_obi_mon.sv */
// Testbench for the OBI monitor: clock, reset, data-file stimulus, expected model, checks.

`timescale 1ns/1ps

`include "obi_mon_macros.svh"

module tb_obi_mon
  import obi_pkg::*;
  import mon_pkg::*;
();

  localparam int unsigned SEED      = 32'h0d0582d2; // Filler address seed.
  localparam int          DRAIN_MAX = 20;           // Cycles to wait for a strobe.

  // Expected transaction record, tagged with its cycle.
  typedef struct packed {
    int unsigned due;   // Cycle in which txn_valid must be high.
    obi_addr_t   addr;
    logic        we;
    obi_be_t     be;
    obi_data_t   rdata;
    logic        err;
  } exp_txn_t;

  // Expected fault strobe, tagged with its cycle.
  typedef struct packed {
    int unsigned due;
    mon_fault_e  code;
  } exp_fault_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req;
  logic       gnt;
  obi_addr_t  addr;
  logic       we;
  obi_be_t    be;
  logic       rvalid;
  obi_data_t  rdata;
  logic       err;
  logic       txn_valid;
  obi_addr_t  txn_addr;
  logic       txn_we;
  obi_be_t    txn_be;
  obi_data_t  txn_rdata;
  logic       txn_err;
  logic       fault_valid;
  mon_fault_e fault_code;

  req_attr_t   attr_q[$];  // Outstanding requests, oldest first.
  exp_txn_t    txn_q[$];   // Records still to come.
  exp_fault_t  fault_q[$]; // Faults still to come.
  int unsigned cyc;        // Rising edges since start.
  int          errors;
  int          checks;
  int          tests;
  int          failed;

  // ==================================================
  // DUT, clock
  // ==================================================

  obi_mon_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req         (req),
    .gnt         (gnt),
    .addr        (addr),
    .we          (we),
    .be          (be),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .err         (err),
    .txn_valid   (txn_valid),
    .txn_addr    (txn_addr),
    .txn_we      (txn_we),
    .txn_be      (txn_be),
    .txn_rdata   (txn_rdata),
    .txn_err     (txn_err),
    .fault_valid (fault_valid),
    .fault_code  (fault_code)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period.
  end

  // ==================================================
  // Helpers
  // ==================================================

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Bus idle; address is don't care, so random filler.
  task automatic drive_idle();
    req    = 1'b0;
    gnt    = 1'b0;
    addr   = $urandom();
    we     = 1'b0;
    be     = '0;
    rvalid = 1'b0;
    rdata  = '0;
    err    = 1'b0;
  endtask

  task automatic drive_cycle(input logic [31:0] v_req, input logic [31:0] v_gnt,
                             input logic [31:0] v_addr, input logic [31:0] v_we,
                             input logic [31:0] v_be, input logic [31:0] v_rvalid,
                             input logic [31:0] v_rdata, input logic [31:0] v_err);
    req    = v_req[0];
    gnt    = v_gnt[0];
    addr   = v_req[0] ? obi_addr_t'(v_addr) : obi_addr_t'($urandom()); // Filler when idle.
    we     = v_we[0];
    be     = obi_be_t'(v_be);
    rvalid = v_rvalid[0];
    rdata  = obi_data_t'(v_rdata);
    err    = v_err[0];
  endtask

  // Waits until every expected strobe has been seen.
  task automatic drain_expected();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while ((txn_q.size() != 0 || fault_q.size() != 0) && waited < DRAIN_MAX) begin
      @(posedge clk_i);
      waited++;
    end
    if (txn_q.size() != 0) begin
      $display("%0t: expected transaction never appeared", $time);
      errors++;
      txn_q.delete();
    end
    if (fault_q.size() != 0) begin
      $display("%0t: expected fault never appeared", $time);
      errors++;
      fault_q.delete();
    end
  endtask

  // ==================================================
  // Expected model, on the bus edge
  // ==================================================

  // The bus cycle before edge cyc carries label cyc - 1,
  // so two cycles later is label cyc + 1.
  always @(posedge clk_i) begin : predict
    exp_txn_t   t;
    exp_fault_t f;
    req_attr_t  a;
    logic       was_full;
    logic       was_empty;
    cyc = cyc + 1;
    if (rst_ni) begin
      was_full  = (attr_q.size() >= `OBI_MON_DEPTH); // State before this edge.
      was_empty = (attr_q.size() == 0);
      if (rvalid) begin
        t.due   = cyc + 1; // Two cycles after the rvalid cycle.
        t.rdata = rdata;
        t.err   = err;
        if (was_empty) begin
          a     = '0; // Orphan carries zero attributes.
          f.due  = cyc + 1;
          f.code = fault_orphan;
          fault_q.push_back(f);
        end else begin
          a = attr_q.pop_front();
        end
        t.addr = a.addr;
        t.we   = a.we;
        t.be   = a.be;
        txn_q.push_back(t);
      end
      if (req && gnt) begin
        if (was_full) begin
          f.due  = cyc + 1; // Request itself is dropped.
          f.code = fault_overflow;
          fault_q.push_back(f);
        end else begin
          a.addr = addr;
          a.we   = we;
          a.be   = be;
          attr_q.push_back(a);
        end
      end
    end
  end

  // ==================================================
  // Output checks, on the falling edge
  // ==================================================

  always @(negedge clk_i) begin : check_outputs
    exp_txn_t   t;
    exp_fault_t f;
    if (rst_ni) begin
      if (txn_valid === 1'b1) begin
        if (txn_q.size() == 0) begin
          $display("%0t: transaction record appeared with no response behind it", $time);
          errors++;
        end else begin
          t = txn_q.pop_front();
          check("txn cycle", cyc, t.due);
          check("txn_addr", txn_addr, t.addr);
          check("txn_we", txn_we, t.we);
          check("txn_be", txn_be, t.be);
          check("txn_rdata", txn_rdata, t.rdata);
          check("txn_err", txn_err, t.err);
        end
      end else if (txn_valid !== 1'b0) begin
        $display("%0t: txn_valid is unknown", $time);
        errors++;
      end
      if (fault_valid === 1'b1) begin
        if (fault_q.size() == 0) begin
          $display("%0t: fault strobe with code %0d came without a cause", $time, fault_code);
          errors++;
        end else begin
          f = fault_q.pop_front();
          check("fault cycle", cyc, f.due);
          check("fault_code", fault_code, f.code);
        end
      end else if (fault_valid !== 1'b0) begin
        $display("%0t: fault_valid is unknown", $time);
        errors++;
      end
    end
  end

  // ==================================================
  // Stimulus from the data file
  // ==================================================

  initial begin : run
    int          fd;
    int          n;
    int          err_start;
    int unsigned rnd;
    string       line;
    string       tag;
    string       name;
    logic [31:0] v[8]; // req gnt addr we be rvalid rdata err.
    rnd       = $urandom(SEED); // Seeded once.
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    failed    = 0;
    err_start = 0;
    name      = "none";
    rst_ni    = 1'b0;
    drive_idle();
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    fd = $fopen("test/obi_mon_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file test/obi_mon_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%s", tag) == 1) begin
          if (tag == "T") begin
            n = $sscanf(line, "%s %s", tag, name);
            err_start = errors;
            tests++;
          end else if (tag == "C") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            @(negedge clk_i);
            drive_cycle(v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
          end else if (tag == "E") begin
            @(negedge clk_i);
            drive_idle();
            drain_expected();
            if (errors > err_start) begin
              failed++;
            end
            $display("test %-16s %s (%0d errors)", name,
                     (errors > err_start) ? "failed" : "ok", errors - err_start);
          end
        end
      end
      $fclose(fd);
    end
    repeat (4) @(negedge clk_i); // Catch late stray strobes.
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_obi_mon
